/* exMulUnit.f */
rtl/mulPkg.sv
rtl/mulPartialStraight.sv
rtl/mulPartialCross.sv
rtl/mulFinalSum.sv
rtl/exMulUnit.sv
verification/exMulUnitTb.sv

/* Makefile */
# Verilator build for the multiply unit testbench

VERILATOR ?= verilator
TOP ?= exMulUnitTb
FILELIST ?= exMulUnit.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= Result: PASSED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/exMulUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module exMulUnitTb;

	localparam int clockPeriod = 8;
	localparam int resetCycles = 8;
	localparam int drainTimeout = 100;
	localparam logic [31:0] seed = 32'd36398;

	typedef struct packed
	{
		logic [63:0] value;
		logic [7:0] cmd;
		logic isUnsigned;
		logic wide;
		logic [2:0] phase;
	} expectEntry;

	logic clock;
	logic rstN;
	logic hold;
	logic inValid;
	logic [31:0] valRs;
	logic [31:0] valRt;
	logic [7:0] cmd;
	logic [7:0] ixt;
	logic [63:0] valRn;
	logic outValid;
	logic [7:0] outCmd;

	expectEntry expectQ[$];
	expectEntry head;
	int pendingCount;
	logic [2:0] validPipe;
	logic [2:0] phase;
	logic [31:0] rngState;
	logic [7:0] nextTag;
	logic [31:0] corners [6];
	logic [31:0] expectedUpper;

	exMulUnit #(
		.tagWidth(8)
	) dut_i
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.inValid(inValid),
		.valRs(valRs),
		.valRt(valRt),
		.cmd(cmd),
		.ixt(ixt),
		.valRn(valRn),
		.outValid(outValid),
		.outCmd(outCmd)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#(clockPeriod / 2) clock = ~clock;
		end
	end

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	// full product first and the narrow rule on top of it
	function automatic logic [63:0] expectedProduct(input logic [31:0] a, input logic [31:0] b,
		input logic isUnsigned, input logic wide);
		logic [63:0] full;
		if (isUnsigned)
			full = {32'h0, a} * {32'h0, b};
		else
			full = {{32{a[31]}}, a} * {{32{b[31]}}, b};
		if (!wide)
			full[63:32] = isUnsigned ? 32'h0 : {32{full[31]}};
		return full;
	endfunction

	function automatic string phaseName(input logic [2:0] p);
		case (p)
			3'd0: return "reset";
			3'd1: return "unsigned wide";
			3'd2: return "signed wide";
			3'd3: return "narrow";
			3'd4: return "pipelining";
			default: return "hold";
		endcase
	endfunction

	task automatic failValue(input string test, input string what,
		input logic [63:0] expected, input logic [63:0] actual);
		$display("** Error [%s] %s: expected %h, actual %h", test, what, expected, actual);
		$display("Result: FAILED");
		$fatal(1, "wrong value");
	endtask

	task automatic failPlain(input string test, input string what);
		$display("%s, in test %s", what, test);
		$display("Result: FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic issueOp(input logic [31:0] a, input logic [31:0] b, input logic [7:0] flags,
		input logic holdLevel, input logic valid);
		logic [31:0] r;
		@(negedge clock);
		r = nextRandom();
		hold = holdLevel;
		inValid = valid;
		valRs = a;
		valRt = b;
		cmd = nextTag;
		nextTag = nextTag + 8'd1;
		// only bits 0 and 2 of ixt count
		ixt = (r[7:0] & 8'hfa) | flags;
	endtask

	// every corner pair and then random operands
	task automatic runMode(input logic [7:0] flags, input int randomCount);
		for (int i = 0; i < 6; i++)
		begin
			for (int j = 0; j < 6; j++)
			begin
				issueOp(corners[i], corners[j], flags, 1'b0, 1'b1);
			end
		end
		repeat (randomCount)
		begin
			issueOp(nextRandom(), nextRandom(), flags, 1'b0, 1'b1);
		end
	endtask

	task automatic waitDrained();
		int cycles;
		cycles = 0;
		@(negedge clock);
		hold = 1'b0;
		inValid = 1'b0;
		while (pendingCount != 0 || validPipe != 3'b000)
		begin
			@(negedge clock);
			cycles++;
			if (cycles > drainTimeout)
				failPlain(phaseName(phase), "pipeline did not drain before the timeout");
		end
	endtask

	// reference model keeps entries in issue order
	always @(posedge clock)
	begin
		expectEntry entry;
		if (!rstN)
		begin
			expectQ.delete();
			validPipe <= 3'b000;
		end
		else if (!hold)
		begin
			// the result on the outputs is taken by this edge
			if (outValid && expectQ.size() > 0)
				void'(expectQ.pop_front());
			if (inValid)
			begin
				entry.value = expectedProduct(valRs, valRt, ixt[0], ixt[2]);
				entry.cmd = cmd;
				entry.isUnsigned = ixt[0];
				entry.wide = ixt[2];
				entry.phase = phase;
				expectQ.push_back(entry);
			end
			validPipe <= {validPipe[1:0], inValid};
		end
		pendingCount <= expectQ.size();
		head <= (expectQ.size() > 0) ? expectQ[0] : '0;
	end

	assign expectedUpper = head.isUnsigned ? 32'h0 : {32{head.value[31]}};

	resetClearsValid: assert property (@(negedge clock) !rstN |-> !outValid)
		else failPlain(phaseName(phase), "outValid was high during reset");

	latencyExact: assert property (@(negedge clock) rstN |-> outValid == validPipe[2])
		else failValue(phaseName(phase), "outValid", {63'h0, validPipe[2]}, {63'h0, outValid});

	resultPending: assert property (@(negedge clock) rstN && outValid |-> pendingCount > 0)
		else failPlain(phaseName(phase), "a result came out with no operation pending");

	resultMatches: assert property (@(negedge clock) rstN && outValid |-> valRn == head.value)
		else failValue(phaseName(head.phase), "valRn", head.value, valRn);

	tagMatches: assert property (@(negedge clock) rstN && outValid |-> outCmd == head.cmd)
		else failValue(phaseName(head.phase), "outCmd", {56'h0, head.cmd}, {56'h0, outCmd});

	narrowUpper: assert property (@(negedge clock)
		rstN && outValid && !head.wide |-> valRn[63:32] == expectedUpper)
		else failValue(phaseName(head.phase), "valRn upper word",
			{32'h0, expectedUpper}, {32'h0, valRn[63:32]});

	holdFreezes: assert property (@(negedge clock)
		rstN && hold |-> $stable(valRn) && $stable(outValid) && $stable(outCmd))
		else failPlain(phaseName(phase), "outputs changed while hold was high");

	initial
	begin
		logic [31:0] r;
		corners = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h1, 32'h80000001};
		rngState = seed;
		nextTag = 8'h0;
		phase = 3'd0;
		rstN = 1'b0;
		hold = 1'b0;
		inValid = 1'b0;
		valRs = 32'h0;
		valRt = 32'h0;
		cmd = 8'h0;
		ixt = 8'h0;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;

		phase = 3'd1;
		runMode(8'h05, 40);
		phase = 3'd2;
		runMode(8'h04, 40);
		phase = 3'd3;
		runMode(8'h01, 20);
		runMode(8'h00, 20);

		phase = 3'd4;
		repeat (60)
		begin
			r = nextRandom();
			issueOp(nextRandom(), nextRandom(), {5'b0, r[1], 1'b0, r[0]}, 1'b0, 1'b1);
		end

		// hold about a quarter of the time with gaps in the stream
		phase = 3'd5;
		repeat (250)
		begin
			r = nextRandom();
			issueOp(nextRandom(), nextRandom(), {5'b0, r[5], 1'b0, r[4]},
				r[1:0] == 2'b00, r[3:2] != 2'b00);
		end

		waitDrained();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/exMulUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module exMulUnit
#(
	parameter int tagWidth = 8
)
(
	input wire clock,
	input wire rstN,
	input wire hold,
	input wire inValid,
	input wire [31:0] valRs,
	input wire [31:0] valRt,
	input wire [tagWidth-1:0] cmd,
	input wire [7:0] ixt,
	output logic [63:0] valRn,
	output logic outValid,
	output logic [tagWidth-1:0] outCmd
);

	mulPkg::mulCtl ctl;
	mulPkg::straightTerms terms;
	mulPkg::crossSum sum;

	// ixt bit 0 unsigned, bit 2 wide, the rest unused
	assign ctl.valid = inValid;
	assign ctl.isUnsigned = ixt[0];
	assign ctl.wide = ixt[2];
	assign ctl.cmd = cmd;

	mulPartialStraight partialStraight
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.ctl(ctl),
		.valRs(valRs),
		.valRt(valRt),
		.terms(terms)
	);

	mulPartialCross partialCross
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.ctl(ctl),
		.valRs(valRs),
		.valRt(valRt),
		.sum(sum)
	);

	mulFinalSum #(
		.tagWidth(tagWidth)
	) finalSum
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.terms(terms),
		.sum(sum),
		.valRn(valRn),
		.outValid(outValid),
		.outCmd(outCmd)
	);

	tagWidthMatches: assert property (@(posedge clock)
		tagWidth == mulPkg::cmdWidth)
		else $error("tagWidth %0d differs from package cmdWidth %0d",
			tagWidth, mulPkg::cmdWidth);

endmodule

`default_nettype wire

/* rtl/mulFinalSum.sv */
`timescale 1ns/1ps
`default_nettype none

module mulFinalSum
#(
	parameter int tagWidth = 8
)
(
	input wire clock,
	input wire rstN,
	input wire hold,
	input wire mulPkg::straightTerms terms,
	input wire mulPkg::crossSum sum,
	output logic [mulPkg::resWidth-1:0] valRn,
	output logic outValid,
	output logic [tagWidth-1:0] outCmd
);

	logic [mulPkg::resWidth-1:0] product;
	logic [mulPkg::resWidth-1:0] result;
	logic narrowFill;

	// wraps modulo 2^64 by width
	assign product = {terms.highProd, terms.lowProd} + sum.value;

	assign narrowFill = product[mulPkg::opWidth-1] & ~terms.ctl.isUnsigned;

	always_comb
	begin
		result = product;
		if (!terms.ctl.wide)
		begin
			// narrow: keep the low word, extend it
			result[mulPkg::resWidth-1:mulPkg::opWidth] = {mulPkg::opWidth{narrowFill}};
		end
	end

	// stage 3
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
		end
		else if (!hold)
		begin
			outValid <= terms.ctl.valid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			valRn <= result;
			outCmd <= terms.ctl.cmd;
		end
	end

	// both partial blocks must stay in step
	validsAgree: assert property (@(posedge clock) disable iff (!rstN)
		terms.ctl.valid == sum.ctl.valid)
		else $error("straight and cross valid bits disagree");

	resultKnown: assert property (@(posedge clock) disable iff (!rstN)
		outValid |-> !$isunknown(valRn))
		else $error("valRn has unknown bits while outValid is high");

endmodule

`default_nettype wire

/* rtl/mulPartialCross.sv */
`timescale 1ns/1ps
`default_nettype none

module mulPartialCross
(
	input wire clock,
	input wire rstN,
	input wire hold,
	input wire mulPkg::mulCtl ctl,
	input wire [mulPkg::opWidth-1:0] valRs,
	input wire [mulPkg::opWidth-1:0] valRt,
	output mulPkg::crossSum sum
);

	logic signed [mulPkg::halfWidth:0] rsLow;
	logic signed [mulPkg::halfWidth:0] rtLow;
	logic signed [mulPkg::halfWidth:0] rsHigh;
	logic signed [mulPkg::halfWidth:0] rtHigh;

	// low half times extended high half
	logic signed [mulPkg::opWidth-1:0] lowHigh;
	logic signed [mulPkg::opWidth-1:0] highLow;

	mulPkg::mulCtl ctl1;
	logic [mulPkg::opWidth-1:0] lowHigh1;
	logic [mulPkg::opWidth-1:0] highLow1;

	logic signExt;
	logic [mulPkg::resWidth-1:0] alignedA;
	logic [mulPkg::resWidth-1:0] alignedB;
	logic [mulPkg::resWidth-1:0] crossTotal;

	assign rsLow = mulPkg::lowHalf(valRs);
	assign rtLow = mulPkg::lowHalf(valRt);
	assign rsHigh = mulPkg::highHalf(valRs, ctl.isUnsigned);
	assign rtHigh = mulPkg::highHalf(valRt, ctl.isUnsigned);

	// signed range of each is within 32 bits
	assign lowHigh = rsLow * rtHigh;
	assign highLow = rsHigh * rtLow;

	// stage 1
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			ctl1.valid <= 1'b0;
		end
		else if (!hold)
		begin
			ctl1 <= ctl;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			lowHigh1 <= lowHigh;
			highLow1 <= highLow;
		end
	end

	// middle columns: a signed product needs its top bit copied up to bit 63,
	// an unsigned one is already positive and just gets zeros
	assign signExt = ~ctl1.isUnsigned;

	assign alignedA = {{mulPkg::halfWidth{lowHigh1[mulPkg::opWidth-1] & signExt}},
		lowHigh1, {mulPkg::halfWidth{1'b0}}};
	assign alignedB = {{mulPkg::halfWidth{highLow1[mulPkg::opWidth-1] & signExt}},
		highLow1, {mulPkg::halfWidth{1'b0}}};

	assign crossTotal = alignedA + alignedB;

	// stage 2
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			sum.ctl.valid <= 1'b0;
		end
		else if (!hold)
		begin
			sum.ctl <= ctl1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			sum.value <= crossTotal;
		end
	end

	validLowAfterReset: assert property (@(posedge clock)
		!rstN |=> !sum.ctl.valid)
		else $error("cross sum valid set on the edge after reset");

endmodule

`default_nettype wire

/* rtl/mulPartialStraight.sv */
`timescale 1ns/1ps
`default_nettype none

module mulPartialStraight
(
	input wire clock,
	input wire rstN,
	input wire hold,
	input wire mulPkg::mulCtl ctl,
	input wire [mulPkg::opWidth-1:0] valRs,
	input wire [mulPkg::opWidth-1:0] valRt,
	output mulPkg::straightTerms terms
);

	logic signed [mulPkg::halfWidth:0] rsHigh;
	logic signed [mulPkg::halfWidth:0] rtHigh;

	logic signed [mulPkg::opWidth-1:0] highHigh;
	logic [mulPkg::opWidth-1:0] lowLow;

	mulPkg::mulCtl ctl1;
	logic [mulPkg::opWidth-1:0] lowProd1;
	logic [mulPkg::opWidth-1:0] highProd1;

	assign rsHigh = mulPkg::highHalf(valRs, ctl.isUnsigned);
	assign rtHigh = mulPkg::highHalf(valRt, ctl.isUnsigned);

	// 32 bits are enough for both, the product never overflows
	assign highHigh = rsHigh * rtHigh;
	assign lowLow = valRs[mulPkg::halfWidth-1:0] * valRt[mulPkg::halfWidth-1:0];

	// stage 1
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			ctl1.valid <= 1'b0;
		end
		else if (!hold)
		begin
			ctl1 <= ctl;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			lowProd1 <= lowLow;
			highProd1 <= highHigh;
		end
	end

	// stage 2, delay only so the terms meet the cross sum
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			terms.ctl.valid <= 1'b0;
		end
		else if (!hold)
		begin
			terms.ctl <= ctl1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			terms.lowProd <= lowProd1;
			terms.highProd <= highProd1;
		end
	end

	holdKeepsTerms: assert property (@(posedge clock) disable iff (!rstN)
		$past(rstN) && $past(hold) |-> $stable(terms))
		else $error("straight terms changed while hold was high");

endmodule

`default_nettype wire

/* rtl/mulPkg.sv */
`default_nettype none

package mulPkg;

	localparam int opWidth = 32;
	localparam int halfWidth = 16;
	localparam int resWidth = 64;

	// width of the command tag carried beside the data
	localparam int cmdWidth = 8;

	typedef struct packed
	{
		logic valid;
		logic isUnsigned;
		logic wide;
		logic [cmdWidth-1:0] cmd;
	} mulCtl;

	// both middle columns, already aligned at bit 16
	typedef struct packed
	{
		logic [resWidth-1:0] value;
		mulCtl ctl;
	} crossSum;

	typedef struct packed
	{
		logic [opWidth-1:0] lowProd;
		logic [opWidth-1:0] highProd;
		mulCtl ctl;
	} straightTerms;

	// upper half with one extension bit, sign or zero
	function automatic logic [halfWidth:0] highHalf(
		input logic [opWidth-1:0] word,
		input logic isUnsigned
	);
		return {word[opWidth-1] & ~isUnsigned, word[opWidth-1:halfWidth]};
	endfunction

	// lower half is never signed
	function automatic logic [halfWidth:0] lowHalf(
		input logic [opWidth-1:0] word
	);
		return {1'b0, word[halfWidth-1:0]};
	endfunction

endpackage

`default_nettype wire
